//--- fd_pkg.sv
// Sizes, register map, configuration struct and log entry struct of the frame detector
package fd_pkg;

	localparam int NUM_FILTERS = 4;
	localparam int FILT_W = $clog2(NUM_FILTERS);
	localparam int LOG_DEPTH = 8;
	localparam int PTR_W = $clog2(LOG_DEPTH);
	localparam int OCC_W = $clog2(LOG_DEPTH + 1);
	localparam int TS_W = 32;
	localparam int LEN_W = 11;
	localparam int REG_ADDR_W = 4;

	// Word addresses of the register port
	localparam logic [REG_ADDR_W-1:0] REG_CTRL = REG_ADDR_W'(0);
	localparam logic [REG_ADDR_W-1:0] REG_ETYPE0 = REG_ADDR_W'(1);
	localparam logic [REG_ADDR_W-1:0] REG_ETYPE1 = REG_ADDR_W'(2);
	localparam logic [REG_ADDR_W-1:0] REG_ETYPE2 = REG_ADDR_W'(3);
	localparam logic [REG_ADDR_W-1:0] REG_ETYPE3 = REG_ADDR_W'(4);
	localparam logic [REG_ADDR_W-1:0] REG_STATUS = REG_ADDR_W'(5);
	localparam logic [REG_ADDR_W-1:0] REG_POP = REG_ADDR_W'(6);
	localparam logic [REG_ADDR_W-1:0] REG_HEAD_TIME = REG_ADDR_W'(7);
	localparam logic [REG_ADDR_W-1:0] REG_HEAD_INFO = REG_ADDR_W'(8);

	// Shared by both matchers
	typedef struct packed {
		logic enable;
		logic [NUM_FILTERS-1:0] filter_en;
		logic [NUM_FILTERS-1:0][15:0] etype;
	} fd_cfg_t;

	// dir is 0 for receive, 1 for transmit
	typedef struct packed {
		logic [TS_W-1:0] timestamp;
		logic dir;
		logic [NUM_FILTERS-1:0] hits;
		logic [LEN_W-1:0] length;
	} log_entry_t;

endpackage

//--- match_if.sv
// Match event channel with valid/ready handshake and source and sink modports
`timescale 1ns/1ps
interface match_if import fd_pkg::*; ();

	logic valid;
	logic ready;
	logic [NUM_FILTERS-1:0] hits;
	logic [LEN_W-1:0] length;

	modport src (
		output valid,
		output hits,
		output length,
		input ready
	);

	modport dst (
		input valid,
		input hits,
		input length,
		output ready
	);

endinterface

//--- frame_matcher.sv
// EtherType matcher for one byte stream, with byte counter and a one-entry event slot
`timescale 1ns/1ps
module frame_matcher import fd_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic srst,
	input logic [7:0] data,
	input logic valid,
	input logic last,
	input fd_cfg_t cfg,
	match_if.src evt
);

	logic [LEN_W-1:0] cnt;
	logic [7:0] etype_hi;
	logic [7:0] etype_lo;
	logic [15:0] etype;
	logic [NUM_FILTERS-1:0] hit;
	logic long_enough;
	logic slot_free;
	logic load;

	// The last byte may itself be byte 13
	assign etype = (cnt == LEN_W'(13)) ? {etype_hi, data} : {etype_hi, etype_lo};

	always_comb begin
		for (int i = 0; i < NUM_FILTERS; i++) begin
			hit[i] = cfg.filter_en[i] && (cfg.etype[i] == etype);
		end
	end

	assign long_enough = cnt >= LEN_W'(13);
	// Slot frees up if the held event transfers this cycle
	assign slot_free = !evt.valid || evt.ready;
	assign load = valid && last && cfg.enable && (|hit) && long_enough && slot_free;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			evt.valid <= 1'b0;
		end else if (srst) begin
			cnt <= '0;
			evt.valid <= 1'b0;
		end else begin
			if (valid) begin
				if (last) begin
					cnt <= '0;
				end else if (cnt != '1) begin
					cnt <= cnt + 1'b1;
				end
			end
			if (load) begin
				evt.valid <= 1'b1;
			end else if (evt.ready) begin
				evt.valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (valid && cnt == LEN_W'(12)) begin
			etype_hi <= data;
		end
		if (valid && cnt == LEN_W'(13)) begin
			etype_lo <= data;
		end
		if (load) begin
			evt.hits <= hit;
			evt.length <= cnt + 1'b1;
		end
	end

endmodule

//--- event_logger.sv
// Event logger with receive-first arbitration, timestamp counter and circular log FIFO
`timescale 1ns/1ps
module event_logger import fd_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic srst,
	match_if.dst rx_evt,
	match_if.dst tx_evt,
	input logic pop,
	output log_entry_t head,
	output logic [OCC_W-1:0] occupancy,
	output logic empty
);

	log_entry_t mem [LOG_DEPTH];
	log_entry_t entry;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [TS_W-1:0] ts;
	logic full;
	logic rx_take;
	logic tx_take;
	logic push;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(LOG_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = occupancy == OCC_W'(LOG_DEPTH);
	assign empty = occupancy == '0;

	// Receive wins a tie
	assign rx_evt.ready = !full;
	assign tx_evt.ready = !full && !rx_evt.valid;

	assign rx_take = rx_evt.valid && rx_evt.ready;
	assign tx_take = tx_evt.valid && tx_evt.ready;
	assign push = rx_take || tx_take;
	assign do_pop = pop && !empty;

	always_comb begin
		entry.timestamp = ts;
		entry.dir = tx_take;
		if (rx_take) begin
			entry.hits = rx_evt.hits;
			entry.length = rx_evt.length;
		end else begin
			entry.hits = tx_evt.hits;
			entry.length = tx_evt.length;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ts <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			occupancy <= '0;
		end else if (srst) begin
			ts <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			occupancy <= '0;
		end else begin
			ts <= ts + 1'b1;
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, do_pop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= entry;
		end
	end

	// Oldest entry stays visible until popped
	assign head = mem[rd_ptr];

endmodule

//--- fd_regs.sv
// Register port decoder with config, soft reset, pop strobe and head registers
`timescale 1ns/1ps
module fd_regs import fd_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic reg_valid,
	input logic reg_write,
	input logic [REG_ADDR_W-1:0] reg_addr,
	input logic [31:0] reg_wdata,
	output logic reg_ready,
	output logic reg_err,
	output logic [31:0] reg_rdata,
	output fd_cfg_t cfg,
	output logic srst,
	output logic pop,
	input log_entry_t head,
	input logic [OCC_W-1:0] occupancy,
	input logic empty
);

	logic capture;
	logic req_q;
	logic write_q;
	logic [REG_ADDR_W-1:0] addr_q;
	logic [31:0] wdata_q;
	log_entry_t head_q;
	logic is_etype;
	logic [FILT_W-1:0] etype_idx;
	logic [31:0] rd_word;
	logic err_next;

	// No new request until the previous one has been answered
	assign capture = reg_valid && !req_q && !reg_ready;

	assign is_etype = (addr_q >= REG_ETYPE0) && (addr_q <= REG_ETYPE3);
	assign etype_idx = FILT_W'(addr_q - REG_ETYPE0);
	assign pop = req_q && write_q && (addr_q == REG_POP) && !empty;

	always_comb begin
		rd_word = '0;
		err_next = 1'b0;
		if (write_q) begin
			err_next = !((addr_q == REG_CTRL) || is_etype || (addr_q == REG_POP));
		end else if (is_etype) begin
			rd_word = {16'd0, cfg.etype[etype_idx]};
		end else begin
			case (addr_q)
				REG_CTRL: rd_word = {24'd0, cfg.filter_en, 2'b00, srst, cfg.enable};
				REG_STATUS: rd_word = 32'(occupancy);
				REG_POP: rd_word = '0;
				REG_HEAD_TIME: rd_word = head_q.timestamp;
				REG_HEAD_INFO: rd_word = {5'd0, head_q.length, 8'd0, head_q.hits, 3'd0, head_q.dir};
				default: err_next = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req_q <= 1'b0;
			reg_ready <= 1'b0;
			reg_err <= 1'b0;
			reg_rdata <= '0;
			cfg <= '0;
			srst <= 1'b0;
			head_q <= '0;
		end else begin
			req_q <= capture;
			reg_ready <= req_q;
			if (req_q) begin
				reg_rdata <= rd_word;
				reg_err <= err_next;
			end
			// srst stays writable while set
			if (req_q && write_q && addr_q == REG_CTRL) begin
				cfg.enable <= wdata_q[0];
				srst <= wdata_q[1];
				cfg.filter_en <= wdata_q[7:4];
			end
			if (req_q && write_q && is_etype) begin
				cfg.etype[etype_idx] <= wdata_q[15:0];
			end
			if (pop) begin
				head_q <= head;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			write_q <= reg_write;
			addr_q <= reg_addr;
			wdata_q <= reg_wdata;
		end
	end

endmodule

//--- frame_detector.sv
// Frame detector top level with two matchers, event logger and register block
`timescale 1ns/1ps
module frame_detector import fd_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [7:0] rx_data,
	input logic rx_valid,
	input logic rx_last,
	input logic [7:0] tx_data,
	input logic tx_valid,
	input logic tx_last,
	input logic reg_valid,
	input logic reg_write,
	input logic [REG_ADDR_W-1:0] reg_addr,
	input logic [31:0] reg_wdata,
	output logic reg_ready,
	output logic [31:0] reg_rdata,
	output logic reg_err
);

	fd_cfg_t cfg;
	logic srst;
	logic pop;
	logic empty;
	log_entry_t head;
	logic [OCC_W-1:0] occupancy;

	match_if rx_if ();
	match_if tx_if ();

	frame_matcher rx_matcher (
		.clk(clk),
		.arst_n(arst_n),
		.srst(srst),
		.data(rx_data),
		.valid(rx_valid),
		.last(rx_last),
		.cfg(cfg),
		.evt(rx_if.src)
	);

	frame_matcher tx_matcher (
		.clk(clk),
		.arst_n(arst_n),
		.srst(srst),
		.data(tx_data),
		.valid(tx_valid),
		.last(tx_last),
		.cfg(cfg),
		.evt(tx_if.src)
	);

	event_logger logger (
		.clk(clk),
		.arst_n(arst_n),
		.srst(srst),
		.rx_evt(rx_if.dst),
		.tx_evt(tx_if.dst),
		.pop(pop),
		.head(head),
		.occupancy(occupancy),
		.empty(empty)
	);

	fd_regs regs (
		.clk(clk),
		.arst_n(arst_n),
		.reg_valid(reg_valid),
		.reg_write(reg_write),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_ready(reg_ready),
		.reg_err(reg_err),
		.reg_rdata(reg_rdata),
		.cfg(cfg),
		.srst(srst),
		.pop(pop),
		.head(head),
		.occupancy(occupancy),
		.empty(empty)
	);

endmodule

//--- fd_asserts.sv
// Concurrent assertions on the match event handshakes and the register port
`timescale 1ns/1ps
module fd_asserts import fd_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic srst,
	input logic rx_valid,
	input logic rx_ready,
	input logic [NUM_FILTERS+LEN_W-1:0] rx_payload,
	input logic tx_valid,
	input logic tx_ready,
	input logic [NUM_FILTERS+LEN_W-1:0] tx_payload,
	input logic reg_valid,
	input logic reg_ready
);

	// Failed assertions so far
	int fails = 0;

	// Soft reset may drop a held event
	assert property (@(posedge clk) disable iff (!arst_n || srst)
		rx_valid && !rx_ready |=> rx_valid)
		else begin
			$error("receive event dropped before ready");
			fails++;
		end

	assert property (@(posedge clk) disable iff (!arst_n || srst)
		tx_valid && !tx_ready |=> tx_valid)
		else begin
			$error("transmit event dropped before ready");
			fails++;
		end

	assert property (@(posedge clk) disable iff (!arst_n || srst)
		rx_valid && !rx_ready |=> $stable(rx_payload))
		else begin
			$error("receive payload changed while held");
			fails++;
		end

	assert property (@(posedge clk) disable iff (!arst_n || srst)
		tx_valid && !tx_ready |=> $stable(tx_payload))
		else begin
			$error("transmit payload changed while held");
			fails++;
		end

	assert property (@(posedge clk) disable iff (!arst_n)
		reg_ready |=> !reg_ready)
		else begin
			$error("reg_ready high for more than one cycle");
			fails++;
		end

	// Answer comes two cycles after the request is seen
	assert property (@(posedge clk) disable iff (!arst_n)
		$rose(reg_ready) |-> $past(reg_valid, 2))
		else begin
			$error("reg_ready rose without a request");
			fails++;
		end

endmodule

//--- tb_frame_detector.sv
// Testbench for the frame detector with stream and register drivers, reference model and checks
`timescale 1ns/1ps
module tb_frame_detector import fd_pkg::*; ();

	logic clk;
	logic arst_n;
	logic [7:0] rx_data;
	logic rx_valid;
	logic rx_last;
	logic [7:0] tx_data;
	logic tx_valid;
	logic tx_last;
	logic reg_valid;
	logic reg_write;
	logic [REG_ADDR_W-1:0] reg_addr;
	logic [31:0] reg_wdata;
	logic reg_ready;
	logic [31:0] reg_rdata;
	logic reg_err;

	fd_cfg_t tb_cfg;
	log_entry_t model[$];
	log_entry_t last_exp;
	logic [31:0] last_ts;
	int errors;
	int mark;
	int tests;
	int failed;

	frame_detector dut (.*);

	bind frame_detector fd_asserts asserts (
		.clk(clk),
		.arst_n(arst_n),
		.srst(srst),
		.rx_valid(rx_if.valid),
		.rx_ready(rx_if.ready),
		.rx_payload({rx_if.hits, rx_if.length}),
		.tx_valid(tx_if.valid),
		.tx_ready(tx_if.ready),
		.tx_payload({tx_if.hits, tx_if.length}),
		.reg_valid(reg_valid),
		.reg_ready(reg_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Expected entry from the EtherType and the configuration written so far
	function automatic log_entry_t ref_entry(input fd_cfg_t c, input logic dir,
			input logic [15:0] et, input int len);
		log_entry_t e;
		e = '0;
		e.dir = dir;
		e.length = LEN_W'(len);
		for (int i = 0; i < NUM_FILTERS; i++) begin
			e.hits[i] = c.enable && c.filter_en[i] && (c.etype[i] == et);
		end
		return e;
	endfunction

	// Head entry rebuilt from the REG_HEAD_INFO layout
	function automatic log_entry_t unpack_info(input logic [31:0] info);
		log_entry_t e;
		e = '0;
		e.dir = info[0];
		e.hits = info[7:4];
		e.length = info[26:16];
		return e;
	endfunction

	task automatic abort(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// Timestamp is not compared
	task automatic check_entry(input string what, input log_entry_t got, input log_entry_t exp);
		if (got.dir !== exp.dir || got.hits !== exp.hits || got.length !== exp.length) begin
			$display("[ERROR] %0t %s: got dir %b hits %b len %0d, expected dir %b hits %b len %0d",
				$time, what, got.dir, got.hits, got.length, exp.dir, exp.hits, exp.length);
			errors++;
		end
	endtask

	task automatic reg_access(input logic wr, input logic [REG_ADDR_W-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int n;
		n = 0;
		@(negedge clk);
		reg_valid = 1'b1;
		reg_write = wr;
		reg_addr = addr;
		reg_wdata = wdata;
		do begin
			@(negedge clk);
			n++;
			if (n > 10) abort("Register port never answered with reg_ready");
		end while (!reg_ready);
		rdata = reg_rdata;
		err = reg_err;
		reg_valid = 1'b0;
	endtask

	task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		reg_access(1'b1, addr, data, rdata, err);
		check_flag("write error flag", err, 1'b0);
	endtask

	task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
		logic err;
		reg_access(1'b0, addr, '0, data, err);
		check_flag("read error flag", err, 1'b0);
	endtask

	task automatic write_ctrl(input logic en, input logic sr, input logic [3:0] fen);
		tb_cfg.enable = en;
		tb_cfg.filter_en = fen;
		write_reg(REG_CTRL, {24'd0, fen, 2'b00, sr, en});
	endtask

	task automatic write_etype(input int idx, input logic [15:0] v);
		tb_cfg.etype[idx] = v;
		write_reg(REG_ADDR_W'(int'(REG_ETYPE0) + idx), {16'd0, v});
	endtask

	// Equal lengths on both streams make the last bytes coincide
	task automatic send_frames(input logic do_rx, input logic do_tx,
			input logic [15:0] et_rx, input logic [15:0] et_tx);
		int len;
		log_entry_t e;
		len = 14 + int'($urandom % 40);
		for (int i = 0; i < len; i++) begin
			@(negedge clk);
			rx_valid = do_rx;
			tx_valid = do_tx;
			rx_last = (i == len - 1);
			tx_last = (i == len - 1);
			rx_data = (i == 12) ? et_rx[15:8] : ((i == 13) ? et_rx[7:0] : 8'($urandom));
			tx_data = (i == 12) ? et_tx[15:8] : ((i == 13) ? et_tx[7:0] : 8'($urandom));
		end
		@(negedge clk);
		rx_valid = 1'b0;
		tx_valid = 1'b0;
		rx_last = 1'b0;
		tx_last = 1'b0;
		repeat (2) @(negedge clk);
		e = ref_entry(tb_cfg, 1'b0, et_rx, len);
		if (do_rx && (|e.hits) && model.size() < LOG_DEPTH) model.push_back(e);
		e = ref_entry(tb_cfg, 1'b1, et_tx, len);
		if (do_tx && (|e.hits) && model.size() < LOG_DEPTH) model.push_back(e);
	endtask

	task automatic wait_occupancy(input int exp);
		logic [31:0] occ;
		int n;
		n = 0;
		read_reg(REG_STATUS, occ);
		while (occ != 32'(exp) && n < 20) begin
			n++;
			read_reg(REG_STATUS, occ);
		end
		check_word("occupancy", occ, 32'(exp));
	endtask

	task automatic pop_and_check();
		logic [31:0] t;
		logic [31:0] info;
		log_entry_t got;
		write_reg(REG_POP, '0);
		read_reg(REG_HEAD_TIME, t);
		read_reg(REG_HEAD_INFO, info);
		got = unpack_info(info);
		if (model.size() == 0) begin
			$display("Popped an entry that the model did not predict at %0t", $time);
			errors++;
		end else begin
			last_exp = model.pop_front();
			check_entry("head entry", got, last_exp);
		end
		if (t < last_ts) begin
			$display("[ERROR] %0t timestamp went back from %0d to %0d", $time, last_ts, t);
			errors++;
		end
		last_ts = t;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == mark) begin
			$display("Test %0d %s: ok", tests, name);
		end else begin
			$display("Test %0d %s: %0d errors", tests, name, errors - mark);
			failed++;
		end
		mark = errors;
	endtask

	initial begin
		logic [31:0] rd;
		logic err;
		void'($urandom(32'h9c56bffa));
		arst_n = 1'b0;
		rx_data = '0;
		rx_valid = 1'b0;
		rx_last = 1'b0;
		tx_data = '0;
		tx_valid = 1'b0;
		tx_last = 1'b0;
		reg_valid = 1'b0;
		reg_write = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		tb_cfg = '0;
		last_exp = '0;
		last_ts = '0;
		errors = 0;
		mark = 0;
		tests = 0;
		failed = 0;
		repeat (3) @(negedge clk);
		arst_n = 1'b1;

		read_reg(REG_STATUS, rd);
		check_word("status after reset", rd, '0);
		write_etype(0, 16'h0800);
		write_etype(1, 16'h0806);
		write_etype(2, 16'h0800);
		write_etype(3, 16'h88f7);
		for (int i = 0; i < NUM_FILTERS; i++) begin
			read_reg(REG_ADDR_W'(int'(REG_ETYPE0) + i), rd);
			check_word("etype readback", rd, {16'd0, tb_cfg.etype[i]});
		end
		write_ctrl(1'b1, 1'b0, 4'hf);
		read_reg(REG_CTRL, rd);
		check_word("ctrl readback", rd, 32'h0000_00f1);
		reg_access(1'b0, REG_ADDR_W'(9), '0, rd, err);
		check_flag("unmapped read error", err, 1'b1);
		reg_access(1'b1, REG_STATUS, 32'h1, rd, err);
		check_flag("status write error", err, 1'b1);
		end_test("register access");

		send_frames(1'b1, 1'b0, 16'h0800, 16'h0);
		send_frames(1'b0, 1'b1, 16'h0, 16'h0806);
		send_frames(1'b1, 1'b0, 16'h1234, 16'h0);
		send_frames(1'b0, 1'b1, 16'h0, 16'h88f7);
		send_frames(1'b1, 1'b0, 16'h0806, 16'h0);
		wait_occupancy(model.size());
		while (model.size() > 0) pop_and_check();
		end_test("matching");

		write_ctrl(1'b0, 1'b0, 4'hf);
		send_frames(1'b1, 1'b1, 16'h0800, 16'h88f7);
		wait_occupancy(0);
		write_ctrl(1'b1, 1'b0, 4'h0);
		send_frames(1'b1, 1'b1, 16'h0800, 16'h88f7);
		wait_occupancy(0);
		// Only filter 2 of the two 0x0800 filters
		write_ctrl(1'b1, 1'b0, 4'b0100);
		send_frames(1'b1, 1'b0, 16'h0800, 16'h0);
		wait_occupancy(1);
		pop_and_check();
		write_ctrl(1'b1, 1'b0, 4'hf);
		end_test("enables");

		send_frames(1'b1, 1'b1, 16'h0806, 16'h0800);
		wait_occupancy(2);
		pop_and_check();
		pop_and_check();
		// Eight fill the FIFO, two wait in the matchers, the rest are lost
		for (int k = 0; k < 6; k++) begin
			send_frames(1'b1, 1'b0, 16'h0800, 16'h0);
			send_frames(1'b0, 1'b1, 16'h0, 16'h88f7);
		end
		wait_occupancy(LOG_DEPTH);
		while (model.size() > 0) pop_and_check();
		// The two held events drain in once there is room
		wait_occupancy(2);
		end_test("simultaneous ends and back-pressure");

		write_ctrl(1'b1, 1'b1, 4'hf);
		read_reg(REG_STATUS, rd);
		check_word("status under soft reset", rd, '0);
		read_reg(REG_CTRL, rd);
		check_word("ctrl under soft reset", rd, 32'h0000_00f3);
		write_ctrl(1'b1, 1'b0, 4'hf);
		last_ts = '0;
		send_frames(1'b0, 1'b1, 16'h0, 16'h0806);
		wait_occupancy(1);
		pop_and_check();
		reg_access(1'b1, REG_POP, '0, rd, err);
		check_flag("pop on empty error", err, 1'b0);
		read_reg(REG_HEAD_INFO, rd);
		check_entry("head after empty pop", unpack_info(rd), last_exp);
		end_test("soft reset");

		errors += dut.asserts.fails;
		$display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- tb.f
fd_pkg.sv
match_if.sv
frame_matcher.sv
event_logger.sv
fd_regs.sv
frame_detector.sv
fd_asserts.sv
tb_frame_detector.sv

//--- Makefile
TOP = tb_frame_detector

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
